//--- verilog/decode_macros.svh
`ifndef DECODE_MACROS_SVH
`define DECODE_MACROS_SVH

`define XLEN            32

`define NUM_WARPS       4
`define WID_BITS        $clog2(`NUM_WARPS)
`define NUM_THREADS     4

// Register number and decoded op widths
`define NR_BITS         5
`define OP_BITS         4
`define MOD_BITS        3
`define CSR_ADDR_BITS   12

// Major opcodes, RV32 base encoding
`define OPC_I           7'b0010011
`define OPC_R           7'b0110011
`define OPC_LUI         7'b0110111
`define OPC_AUIPC       7'b0010111
`define OPC_JAL         7'b1101111
`define OPC_JALR        7'b1100111
`define OPC_B           7'b1100011
`define OPC_L           7'b0000011
`define OPC_S           7'b0100011
`define OPC_FENCE       7'b0001111
`define OPC_SYS         7'b1110011

// LSU op code for FENCE, outside the load/store range
`define LSU_FENCE       4'hf

`endif

//--- verilog/decode_pkg.sv
`include "decode_macros.svh"

package decode_pkg;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_fmt_t;

    // One instruction word, six ways to read it
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
        b_fmt_t b;
        u_fmt_t u;
        j_fmt_t j;
    } instr_u;

    typedef enum logic [1:0] {
        EX_ALU = 2'd0,
        EX_LSU = 2'd1,
        EX_SFU = 2'd2
    } ex_type_e;

    typedef enum logic [`OP_BITS-1:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
        ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_LUI, ALU_AUIPC
    } alu_op_e;

    typedef enum logic [`OP_BITS-1:0] {
        BR_EQ, BR_NE, BR_LT, BR_GE, BR_LTU, BR_GEU, BR_JAL, BR_JALR,
        BR_ECALL, BR_EBREAK, BR_URET, BR_SRET, BR_MRET
    } br_op_e;

    // Same order as funct3
    typedef enum logic [`OP_BITS-1:0] {
        M_MUL, M_MULH, M_MULHSU, M_MULHU, M_DIV, M_DIVU, M_REM, M_REMU
    } m_op_e;

    typedef enum logic [`OP_BITS-1:0] {
        SFU_CSRRW = 4'd1,   // matches funct3[1:0]
        SFU_CSRRS = 4'd2,
        SFU_CSRRC = 4'd3
    } sfu_op_e;

    typedef struct packed {
        logic [`WID_BITS-1:0]    wid;
        logic [`NUM_THREADS-1:0] tmask;
        logic [`XLEN-1:0]        pc;
        instr_u                  instr;
    } fetch_t;

    typedef struct packed {
        logic [`WID_BITS-1:0]    wid;
        logic [`NUM_THREADS-1:0] tmask;
        logic [`XLEN-1:0]        pc;
        ex_type_e                ex_type;
        logic [`OP_BITS-1:0]     op_type;
        logic [`MOD_BITS-1:0]    op_mod;   // [0] branch/jump, [1] M op
        logic                    use_pc;
        logic                    use_imm;
        logic [`XLEN-1:0]        imm;
        logic                    wb;
        logic [`NR_BITS-1:0]     rd;
        logic [`NR_BITS-1:0]     rs1;
        logic [`NR_BITS-1:0]     rs2;
        logic                    is_branch;
    } decode_t;

endpackage

//--- verilog/imm_gen.sv
`timescale 1ns/1ps
`include "decode_macros.svh"

module imm_gen import decode_pkg::*; (
    input  instr_u           instr,
    input  logic [6:0]       opcode,
    output logic [`XLEN-1:0] imm
);

    logic [2:0]  funct3;
    logic        is_shift;
    logic        is_ret;
    logic [11:0] i_imm;
    logic [11:0] s_imm;
    logic [12:0] b_imm;
    logic [20:0] j_imm;

    assign funct3   = instr.i.funct3;
    assign is_shift = (funct3 == 3'd1) || (funct3 == 3'd5);
    assign i_imm    = instr.i.imm;
    assign s_imm    = {instr.s.imm_hi, instr.s.imm_lo};
    assign b_imm    = {instr.b.imm12, instr.b.imm11, instr.b.imm10_5, instr.b.imm4_1, 1'b0};
    assign j_imm    = {instr.j.imm20, instr.j.imm19_12, instr.j.imm11, instr.j.imm10_1, 1'b0};

    // ECALL, EBREAK and the xRET forms by funct12
    always_comb begin
        case (i_imm)
            12'h000, 12'h001, 12'h002, 12'h102, 12'h302: is_ret = 1'b1;
            default: is_ret = 1'b0;
        endcase
    end

    always_comb begin
        imm = '0;
        case (opcode)
            `OPC_I: begin
                if (is_shift)
                    imm = {{(`XLEN-5){1'b0}}, instr.r.rs2};   // shamt
                else
                    imm = {{(`XLEN-12){i_imm[11]}}, i_imm};
            end
            `OPC_JALR, `OPC_L: imm = {{(`XLEN-12){i_imm[11]}}, i_imm};
            `OPC_S:            imm = {{(`XLEN-12){s_imm[11]}}, s_imm};
            `OPC_B: begin
                if (funct3[2:1] != 2'b01)
                    imm = {{(`XLEN-13){b_imm[12]}}, b_imm};
            end
            `OPC_LUI, `OPC_AUIPC: imm = `XLEN'($signed({instr.u.imm, 12'h000}));
            `OPC_JAL:             imm = {{(`XLEN-21){j_imm[20]}}, j_imm};
            `OPC_SYS: begin
                if (funct3[1:0] != 2'b00) begin
                    imm[`CSR_ADDR_BITS-1:0] = i_imm;
                    if (funct3[2])
                        imm[`CSR_ADDR_BITS +: `NR_BITS] = instr.i.rs1;   // uimm
                end else if (funct3 == 3'd0 && is_ret) begin
                    imm = `XLEN'd4;   // return address offset
                end
            end
            default: ;
        endcase
    end

endmodule

//--- verilog/op_decoder.sv
`timescale 1ns/1ps
`include "decode_macros.svh"

module op_decoder import decode_pkg::*; (
    input  instr_u               instr,
    output ex_type_e             ex_type,
    output logic [`OP_BITS-1:0]  op_type,
    output logic [`MOD_BITS-1:0] op_mod,
    output logic                 use_pc,
    output logic                 use_imm,
    output logic                 use_rd,
    output logic [`NR_BITS-1:0]  rd,
    output logic [`NR_BITS-1:0]  rs1,
    output logic [`NR_BITS-1:0]  rs2,
    output logic                 is_wstall,
    output logic                 is_branch
);

    logic [6:0]  opcode;
    logic [2:0]  funct3;
    logic [6:0]  funct7;
    logic [11:0] funct12;
    logic        use_rs1;
    logic        use_rs2;
    logic        br_ok;
    logic        sys_ok;
    br_op_e      br_code;
    br_op_e      sys_code;

    assign opcode  = instr.r.opcode;
    assign funct3  = instr.r.funct3;
    assign funct7  = instr.r.funct7;
    assign funct12 = instr.i.imm;

    // SUB exists only in the register form
    function automatic alu_op_e alu_fn(input logic [2:0] f3, input logic alt, input logic is_op);
        alu_op_e op;
        case (f3)
            3'd0: op = (is_op && alt) ? ALU_SUB : ALU_ADD;
            3'd1: op = ALU_SLL;
            3'd2: op = ALU_SLT;
            3'd3: op = ALU_SLTU;
            3'd4: op = ALU_XOR;
            3'd5: op = alt ? ALU_SRA : ALU_SRL;
            3'd6: op = ALU_OR;
            3'd7: op = ALU_AND;
        endcase
        return op;
    endfunction

    function automatic m_op_e m_fn(input logic [2:0] f3);
        return m_op_e'({1'b0, f3});
    endfunction

    function automatic logic br_fn(input logic [2:0] f3, output br_op_e op);
        logic ok;
        ok = 1'b1;
        case (f3)
            3'd0: op = BR_EQ;
            3'd1: op = BR_NE;
            3'd4: op = BR_LT;
            3'd5: op = BR_GE;
            3'd6: op = BR_LTU;
            3'd7: op = BR_GEU;
            default: begin
                op = BR_EQ;
                ok = 1'b0;
            end
        endcase
        return ok;
    endfunction

    function automatic logic sys_fn(input logic [11:0] f12, output br_op_e op);
        logic ok;
        ok = 1'b1;
        case (f12)
            12'h000: op = BR_ECALL;
            12'h001: op = BR_EBREAK;
            12'h002: op = BR_URET;
            12'h102: op = BR_SRET;
            12'h302: op = BR_MRET;
            default: begin
                op = BR_EQ;
                ok = 1'b0;
            end
        endcase
        return ok;
    endfunction

    always_comb begin
        br_ok     = br_fn(funct3, br_code);
        sys_ok    = sys_fn(funct12, sys_code);
        ex_type   = EX_ALU;
        op_type   = '0;
        op_mod    = '0;
        use_pc    = 1'b0;
        use_imm   = 1'b0;
        use_rd    = 1'b0;
        use_rs1   = 1'b0;
        use_rs2   = 1'b0;
        is_wstall = 1'b0;
        is_branch = 1'b0;
        case (opcode)
            `OPC_I: begin
                op_type = alu_fn(funct3, funct7[5], 1'b0);
                use_imm = 1'b1;
                use_rd  = 1'b1;
                use_rs1 = 1'b1;
            end
            `OPC_R: begin
                if (funct7[0]) begin
                    op_type   = m_fn(funct3);
                    op_mod[1] = 1'b1;
                end else begin
                    op_type = alu_fn(funct3, funct7[5], 1'b1);
                end
                use_rd  = 1'b1;
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
            end
            `OPC_LUI: begin
                op_type = ALU_LUI;
                use_imm = 1'b1;
                use_rd  = 1'b1;
            end
            `OPC_AUIPC: begin
                op_type = ALU_AUIPC;
                use_pc  = 1'b1;
                use_imm = 1'b1;
                use_rd  = 1'b1;
            end
            `OPC_JAL: begin
                op_type   = BR_JAL;
                op_mod[0] = 1'b1;
                use_pc    = 1'b1;
                use_imm   = 1'b1;
                use_rd    = 1'b1;
                is_wstall = 1'b1;
                is_branch = 1'b1;
            end
            `OPC_JALR: begin
                op_type   = BR_JALR;
                op_mod[0] = 1'b1;
                use_imm   = 1'b1;
                use_rd    = 1'b1;
                use_rs1   = 1'b1;
                is_wstall = 1'b1;
                is_branch = 1'b1;
            end
            `OPC_B: begin
                if (br_ok) begin
                    op_type   = br_code;
                    op_mod[0] = 1'b1;
                    use_pc    = 1'b1;
                    use_imm   = 1'b1;
                    use_rs1   = 1'b1;
                    use_rs2   = 1'b1;
                    is_wstall = 1'b1;
                    is_branch = 1'b1;
                end
            end
            `OPC_L: begin
                ex_type = EX_LSU;
                op_type = {1'b0, funct3};
                use_imm = 1'b1;
                use_rd  = 1'b1;
                use_rs1 = 1'b1;
            end
            `OPC_S: begin
                ex_type = EX_LSU;
                op_type = {1'b1, funct3};   // store flag in bit 3
                use_imm = 1'b1;
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
            end
            `OPC_FENCE: begin
                ex_type = EX_LSU;
                op_type = `LSU_FENCE;
            end
            `OPC_SYS: begin
                if (funct3[1:0] != 2'b00) begin
                    ex_type   = EX_SFU;
                    op_type   = sfu_op_e'({2'b00, funct3[1:0]});
                    use_imm   = funct3[2];
                    use_rd    = 1'b1;
                    use_rs1   = ~funct3[2];   // rs1 field is the uimm otherwise
                    is_wstall = 1'b1;
                end else if (funct3 == 3'd0 && sys_ok) begin
                    op_type   = sys_code;
                    op_mod[0] = 1'b1;
                    use_pc    = 1'b1;
                    use_imm   = 1'b1;
                    use_rd    = 1'b1;
                    is_wstall = 1'b1;
                end
            end
            default: ;
        endcase
    end

    assign rd  = use_rd  ? instr.r.rd  : '0;
    assign rs1 = use_rs1 ? instr.r.rs1 : '0;
    assign rs2 = use_rs2 ? instr.r.rs2 : '0;

endmodule

//--- verilog/decode_buffer.sv
`timescale 1ns/1ps

module decode_buffer import decode_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,
    input  logic    flush,
    input  logic    in_valid,
    output logic    in_ready,
    input  decode_t in_data,
    output logic    out_valid,
    input  logic    out_ready,
    output decode_t out_data
);

    logic    full_q;
    decode_t data_q;

    // Accept when empty or draining; never during a flush
    assign in_ready = ~flush & (~full_q | out_ready);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            full_q <= 1'b0;
        end else if (flush) begin
            full_q <= 1'b0;
        end else if (in_ready) begin
            full_q <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready)
            data_q <= in_data;
    end

    assign out_valid = full_q;
    assign out_data  = data_q;

endmodule

//--- verilog/decode_stage.sv
`timescale 1ns/1ps
`include "decode_macros.svh"

module decode_stage import decode_pkg::*; (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 flush,
    input  logic                 fetch_valid,
    output logic                 fetch_ready,
    input  fetch_t               fetch_data,
    output logic                 decode_valid,
    input  logic                 decode_ready,
    output decode_t              decode_data,
    output logic                 sched_valid,
    output logic [`WID_BITS-1:0] sched_wid,
    output logic                 sched_wstall
);

    ex_type_e             ex_type;
    logic [`OP_BITS-1:0]  op_type;
    logic [`MOD_BITS-1:0] op_mod;
    logic                 use_pc;
    logic                 use_imm;
    logic                 use_rd;
    logic [`NR_BITS-1:0]  rd;
    logic [`NR_BITS-1:0]  rs1;
    logic [`NR_BITS-1:0]  rs2;
    logic                 is_wstall;
    logic                 is_branch;
    logic [`XLEN-1:0]     imm;
    decode_t              dec;

    op_decoder i_op_decoder (
        .instr     (fetch_data.instr),
        .ex_type   (ex_type),
        .op_type   (op_type),
        .op_mod    (op_mod),
        .use_pc    (use_pc),
        .use_imm   (use_imm),
        .use_rd    (use_rd),
        .rd        (rd),
        .rs1       (rs1),
        .rs2       (rs2),
        .is_wstall (is_wstall),
        .is_branch (is_branch)
    );

    imm_gen i_imm_gen (
        .instr  (fetch_data.instr),
        .opcode (fetch_data.instr.r.opcode),
        .imm    (imm)
    );

    always_comb begin
        dec.wid       = fetch_data.wid;
        dec.tmask     = fetch_data.tmask;
        dec.pc        = fetch_data.pc;
        dec.ex_type   = ex_type;
        dec.op_type   = op_type;
        dec.op_mod    = op_mod;
        dec.use_pc    = use_pc;
        dec.use_imm   = use_imm;
        dec.imm       = imm;
        dec.wb        = use_rd && (rd != '0);   // x0 writes dropped
        dec.rd        = rd;
        dec.rs1       = rs1;
        dec.rs2       = rs2;
        dec.is_branch = is_branch;
    end

    decode_buffer i_decode_buffer (
        .clk       (clk),
        .rst_n     (rst_n),
        .flush     (flush),
        .in_valid  (fetch_valid),
        .in_ready  (fetch_ready),
        .in_data   (dec),
        .out_valid (decode_valid),
        .out_ready (decode_ready),
        .out_data  (decode_data)
    );

    // Scheduler sees the instruction in its fetch cycle
    assign sched_valid  = fetch_valid && fetch_ready;
    assign sched_wid    = fetch_data.wid;
    assign sched_wstall = is_wstall;

endmodule

//--- verif/decode_assertions.sv
`timescale 1ns/1ps

module decode_assertions import decode_pkg::*; (
    input logic    clk,
    input logic    rst_n,
    input logic    flush,
    input logic    decode_valid,
    input logic    decode_ready,
    input decode_t decode_data,
    input logic    sched_valid
);

    // Stalled output keeps its data
    hold_a: assert property (@(posedge clk) disable iff (!rst_n)
        decode_valid && !decode_ready && !flush |=> decode_valid && $stable(decode_data))
        else $error("decode output dropped or changed while stalled");

    // Accepted instruction shows up one cycle later
    sched_a: assert property (@(posedge clk) disable iff (!rst_n)
        sched_valid |=> decode_valid)
        else $error("accepted instruction missing from the decode output");

    flush_a: assert property (@(posedge clk) disable iff (!rst_n)
        flush |=> !decode_valid)
        else $error("decode output valid in the cycle after a flush");

endmodule

bind decode_stage decode_assertions i_decode_assertions (
    .clk          (clk),
    .rst_n        (rst_n),
    .flush        (flush),
    .decode_valid (decode_valid),
    .decode_ready (decode_ready),
    .decode_data  (decode_data),
    .sched_valid  (sched_valid)
);

//--- verif/decode_tb.sv
`timescale 1ns/1ps
`include "decode_macros.svh"

module decode_tb import decode_pkg::*; ();

    localparam logic [31:0] SEED       = 32'h25e792dd;
    localparam int          N_RANDOM   = 1500;
    localparam int          N_AFTER    = 100;
    localparam int          MAX_CYCLES = 20000;

    // Base ALU op per funct3 before the funct7 alternates
    localparam alu_op_e ALU_MAP [8] = '{ALU_ADD, ALU_SLL, ALU_SLT, ALU_SLTU,
                                        ALU_XOR, ALU_SRL, ALU_OR, ALU_AND};
    localparam br_op_e  BR_MAP  [8] = '{BR_EQ, BR_NE, BR_EQ, BR_EQ,
                                        BR_LT, BR_GE, BR_LTU, BR_GEU};

    localparam logic [31:0] DIRECTED [32] = '{
        32'h00500093, 32'hfff00113, 32'h00311193, 32'h4041d213,   // addi, slli, srai
        32'h00000013, 32'h402081b3, 32'h002081b3, 32'h022081b3,   // nop, sub, add, mul
        32'h0220c1b3, 32'h0220f1b3, 32'h123452b7, 32'hfffff317,   // div, remu, lui, auipc
        32'h008000ef, 32'hffdff06f, 32'h000080e7, 32'hfe208ee3,   // jal, jalr, beq
        32'h0020c463, 32'h0020a063, 32'hffc12283, 32'h00512e23,   // blt, bad branch, lw, sw
        32'h0ff0000f, 32'h00000073, 32'h00100073, 32'h00200073,   // fence, ecall, ebreak, uret
        32'h10200073, 32'h30200073, 32'h00500073, 32'h300110f3,   // sret, mret, bad f12, csrrw
        32'h3002e0f3, 32'h00004073, 32'hffffffff, 32'h0000000b    // csrrsi, bad sys, bad opcodes
    };

    logic                 clk;
    logic                 rst_n;
    logic                 flush;
    logic                 fetch_valid;
    logic                 fetch_ready;
    fetch_t               fetch_data;
    logic                 decode_valid;
    logic                 decode_ready;
    decode_t              decode_data;
    logic                 sched_valid;
    logic [`WID_BITS-1:0] sched_wid;
    logic                 sched_wstall;

    logic [31:0] rng_state;
    logic [31:0] next_pc;
    string       test_name;
    fetch_t      stim_q[$];
    decode_t     exp_q[$];
    string       name_q[$];
    int          cycles;
    int          in_count;
    int          out_count;
    int          dropped;
    logic        after_flush;

    decode_stage i_dut (.*);

    always #2 clk = ~clk;

    function automatic logic [31:0] lcg_next();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return {rng_state[15:0], rng_state[31:16]};   // Weak low bits moved up
    endfunction

    function automatic logic chance(input int pct);
        return int'(lcg_next() % 32'd100) < pct;
    endfunction

    task automatic stop_on_error(input string what);
        $display("%s", what);
        $display("Errors found");
        $fatal(1);
    endtask

    // Expected decode from the ISA field positions
    function automatic decode_t decode_ref(input fetch_t f, output logic wstall);
        decode_t     d;
        logic [31:0] w;
        logic [2:0]  f3;
        logic        use_rd;
        logic        use_rs1;
        logic        use_rs2;
        w       = f.instr;
        f3      = w[14:12];
        d       = '0;
        d.wid   = f.wid;
        d.tmask = f.tmask;
        d.pc    = f.pc;
        wstall  = 1'b0;
        use_rd  = 1'b0;
        use_rs1 = 1'b0;
        use_rs2 = 1'b0;
        case (w[6:0])
            `OPC_I: begin
                d.op_type = (f3 == 3'd5 && w[30]) ? ALU_SRA : ALU_MAP[f3];
                if (f3 == 3'd1 || f3 == 3'd5)
                    d.imm = {27'd0, w[24:20]};
                else
                    d.imm = {{20{w[31]}}, w[31:20]};
                d.use_imm = 1'b1;
                use_rd    = 1'b1;
                use_rs1   = 1'b1;
            end
            `OPC_R: begin
                if (w[25]) begin
                    d.op_type = {1'b0, f3};
                    d.op_mod  = 3'b010;
                end else if (w[30] && f3 == 3'd0) begin
                    d.op_type = ALU_SUB;
                end else begin
                    d.op_type = (f3 == 3'd5 && w[30]) ? ALU_SRA : ALU_MAP[f3];
                end
                use_rd  = 1'b1;
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
            end
            `OPC_LUI, `OPC_AUIPC: begin
                d.op_type = (w[6:0] == `OPC_LUI) ? ALU_LUI : ALU_AUIPC;
                d.use_pc  = (w[6:0] == `OPC_AUIPC);
                d.use_imm = 1'b1;
                d.imm     = {w[31:12], 12'd0};
                use_rd    = 1'b1;
            end
            `OPC_JAL, `OPC_JALR: begin
                if (w[6:0] == `OPC_JAL) begin
                    d.op_type = BR_JAL;
                    d.use_pc  = 1'b1;
                    d.imm     = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
                end else begin
                    d.op_type = BR_JALR;
                    d.imm     = {{20{w[31]}}, w[31:20]};
                    use_rs1   = 1'b1;
                end
                d.op_mod    = 3'b001;
                d.use_imm   = 1'b1;
                d.is_branch = 1'b1;
                use_rd      = 1'b1;
                wstall      = 1'b1;
            end
            `OPC_B: begin
                if (f3 != 3'd2 && f3 != 3'd3) begin
                    d.op_type   = BR_MAP[f3];
                    d.op_mod    = 3'b001;
                    d.use_pc    = 1'b1;
                    d.use_imm   = 1'b1;
                    d.imm       = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
                    d.is_branch = 1'b1;
                    use_rs1     = 1'b1;
                    use_rs2     = 1'b1;
                    wstall      = 1'b1;
                end
            end
            `OPC_L, `OPC_S: begin
                d.ex_type = EX_LSU;
                d.op_type = {w[6:0] == `OPC_S, f3};
                d.use_imm = 1'b1;
                if (w[6:0] == `OPC_S)
                    d.imm = {{20{w[31]}}, w[31:25], w[11:7]};
                else
                    d.imm = {{20{w[31]}}, w[31:20]};
                use_rd  = (w[6:0] == `OPC_L);
                use_rs1 = 1'b1;
                use_rs2 = (w[6:0] == `OPC_S);
            end
            `OPC_FENCE: begin
                d.ex_type = EX_LSU;
                d.op_type = `LSU_FENCE;
            end
            `OPC_SYS: begin
                if (f3[1:0] != 2'b00) begin
                    d.ex_type = EX_SFU;
                    d.op_type = {2'b00, f3[1:0]};
                    d.use_imm = f3[2];
                    d.imm     = {15'd0, f3[2] ? w[19:15] : 5'd0, w[31:20]};
                    use_rd    = 1'b1;
                    use_rs1   = !f3[2];
                    wstall    = 1'b1;
                end else if (f3 == 3'd0) begin
                    case (w[31:20])
                        12'h000: d.op_type = BR_ECALL;
                        12'h001: d.op_type = BR_EBREAK;
                        12'h002: d.op_type = BR_URET;
                        12'h102: d.op_type = BR_SRET;
                        12'h302: d.op_type = BR_MRET;
                        default: d.op_type = '0;
                    endcase
                    if (d.op_type != '0) begin
                        d.op_mod  = 3'b001;
                        d.use_pc  = 1'b1;
                        d.use_imm = 1'b1;
                        d.imm     = 32'd4;
                        use_rd    = 1'b1;
                        wstall    = 1'b1;
                    end
                end
            end
            default: ;
        endcase
        d.rd  = use_rd  ? w[11:7]  : 5'd0;
        d.rs1 = use_rs1 ? w[19:15] : 5'd0;
        d.rs2 = use_rs2 ? w[24:20] : 5'd0;
        d.wb  = use_rd && (d.rd != 5'd0);
        return d;
    endfunction

    function automatic logic [31:0] random_word();
        logic [31:0] r;
        logic [31:0] s;
        logic [4:0]  rd;
        logic [2:0]  f3;
        logic [11:0] f12;
        r  = lcg_next();
        s  = lcg_next();
        rd = (s[31:29] == 3'd0) ? 5'd0 : s[4:0];   // x0 targets now and then
        f3 = s[7:5];
        case (s[10:8])
            3'd0: f12 = 12'h000;
            3'd1: f12 = 12'h001;
            3'd2: f12 = 12'h002;
            3'd3: f12 = 12'h102;
            3'd4: f12 = 12'h302;
            default: f12 = r[31:20];
        endcase
        case (r[3:0])
            4'd0:  return {r[31:20], s[12:8], f3, rd, `OPC_I};
            4'd1:  return {1'b0, r[30], 5'd0, r[24:20], s[12:8], (r[4] ? 3'd5 : 3'd1), rd, `OPC_I};
            4'd2:  return {1'b0, r[30], 5'd0, r[24:20], s[12:8], f3, rd, `OPC_R};
            4'd3:  return {7'd1, r[24:20], s[12:8], f3, rd, `OPC_R};
            4'd4:  return {r[31:12], rd, `OPC_LUI};
            4'd5:  return {r[31:12], rd, `OPC_AUIPC};
            4'd6:  return {r[31:12], rd, `OPC_JAL};
            4'd7:  return {r[31:20], s[12:8], 3'd0, rd, `OPC_JALR};
            4'd8:  return {r[31:25], r[24:20], s[12:8], f3, r[11:7], `OPC_B};
            4'd9:  return {r[31:20], s[12:8], f3, rd, `OPC_L};
            4'd10: return {r[31:25], r[24:20], s[12:8], f3, r[11:7], `OPC_S};
            4'd11: return {r[31:20], s[12:8], 3'd0, rd, `OPC_FENCE};
            4'd12: return {f12, 5'd0, 3'd0, rd, `OPC_SYS};
            4'd13: return {r[31:20], s[12:8], f3[2], (f3[1:0] == 2'b00 ? 2'b01 : f3[1:0]), rd, `OPC_SYS};
            4'd14: return {r[31:20], s[12:8], 3'd4, rd, `OPC_SYS};
            default: return r;
        endcase
    endfunction

    function automatic fetch_t make_fetch(input logic [31:0] w);
        fetch_t      f;
        logic [31:0] r;
        r       = lcg_next();
        f.wid   = r[`WID_BITS-1:0];
        f.tmask = r[4 +: `NUM_THREADS];
        f.pc    = next_pc;
        f.instr = w;
        next_pc = next_pc + 32'd4;
        return f;
    endfunction

    task automatic wait_fetch();
        logic fired;
        do begin
            @(negedge clk);
            fired = fetch_valid && fetch_ready;
            @(posedge clk);
            #1;
        end while (!fired);
        fetch_valid = 1'b0;
    endtask

    task automatic send_one(input fetch_t f);
        fetch_data  = f;
        fetch_valid = 1'b1;
        wait_fetch();
    endtask

    task automatic stream_queue(input int gap_pct, input int stall_pct);
        logic fired;
        while (stim_q.size() != 0 || fetch_valid) begin
            @(negedge clk);
            fired = fetch_valid && fetch_ready;
            @(posedge clk);
            #1;
            if (fired || !fetch_valid) begin
                if (stim_q.size() != 0 && !chance(gap_pct)) begin
                    fetch_data  = stim_q.pop_front();
                    fetch_valid = 1'b1;
                end else begin
                    fetch_valid = 1'b0;
                end
            end
            decode_ready = !chance(stall_pct);
        end
    endtask

    task automatic drain();
        decode_ready = 1'b1;
        while (exp_q.size() != 0 || decode_valid) begin
            @(posedge clk);
            #1;
        end
    endtask

    // Full buffer, stalled fetch, then one flush cycle
    task automatic flush_check();
        decode_ready = 1'b0;
        send_one(make_fetch(random_word()));
        fetch_data  = make_fetch(random_word());
        fetch_valid = 1'b1;
        flush       = 1'b1;
        @(posedge clk);
        #1;
        flush        = 1'b0;
        decode_ready = 1'b1;
        wait_fetch();
        drain();
    endtask

    // Scoreboard sampled mid-cycle where every signal is settled
    always @(negedge clk) begin
        decode_t want;
        logic    stall;
        string   name;
        logic    ready_exp;
        if (rst_n) begin
            // Pending entries stand for the buffer contents
            ready_exp = !flush && (exp_q.size() == 0 || decode_ready);
            assert (fetch_ready === ready_exp) else stop_on_error($sformatf(
                "Mismatch %s fetch_ready expected %b actual %b", test_name,
                ready_exp, fetch_ready));
            if (after_flush)
                assert (!decode_valid) else stop_on_error("Output valid right after a flush");
            if (flush) begin
                dropped = dropped + exp_q.size();
                exp_q.delete();
                name_q.delete();
            end else if (decode_valid && decode_ready) begin
                assert (exp_q.size() != 0) else stop_on_error("Output with nothing pending");
                want = exp_q.pop_front();
                name = name_q.pop_front();
                assert (decode_data === want) else stop_on_error($sformatf(
                    "Mismatch %s expected %h actual %h", name, want, decode_data));
                out_count++;
            end
            assert (sched_valid === (fetch_valid && fetch_ready)) else
                stop_on_error("Scheduler notice does not follow the fetch transfer");
            if (fetch_valid && fetch_ready) begin
                want = decode_ref(fetch_data, stall);
                assert (sched_wid === fetch_data.wid) else stop_on_error($sformatf(
                    "Mismatch %s sched_wid expected %h actual %h", test_name,
                    fetch_data.wid, sched_wid));
                assert (sched_wstall === stall) else stop_on_error($sformatf(
                    "Mismatch %s sched_wstall expected %b actual %b", test_name,
                    stall, sched_wstall));
                exp_q.push_back(want);
                name_q.push_back(test_name);
                in_count++;
            end
            after_flush = flush;
        end
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        assert (cycles < MAX_CYCLES) else stop_on_error("Run timed out before all tests ended");
    end

    initial begin
        clk          = 1'b0;
        rst_n        = 1'b0;
        flush        = 1'b0;
        fetch_valid  = 1'b0;
        fetch_data   = '0;
        decode_ready = 1'b0;
        rng_state    = SEED;
        next_pc      = 32'h0000_1000;
        test_name    = "reset";
        cycles       = 0;
        in_count     = 0;
        out_count    = 0;
        dropped      = 0;
        after_flush  = 1'b0;
        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;

        test_name = "directed";
        for (int k = 0; k < 32; k++)
            stim_q.push_back(make_fetch(DIRECTED[k]));
        stream_queue(0, 0);
        drain();

        test_name = "random";
        repeat (N_RANDOM) stim_q.push_back(make_fetch(random_word()));
        stream_queue(15, 25);
        drain();

        test_name = "flush";
        repeat (10) flush_check();
        repeat (N_AFTER) stim_q.push_back(make_fetch(random_word()));
        stream_queue(10, 20);
        drain();

        assert (exp_q.size() == 0 && in_count == out_count + dropped) begin
            $display("No errors");
            $finish;
        end else begin
            stop_on_error($sformatf("Mismatch instruction count expected %0d actual %0d",
                in_count - dropped, out_count));
        end
    end

endmodule

//--- vlog.f
+incdir+verilog
verilog/decode_pkg.sv
verilog/imm_gen.sv
verilog/op_decoder.sv
verilog/decode_buffer.sv
verilog/decode_stage.sv
verif/decode_assertions.sv
verif/decode_tb.sv

//--- Makefile
TOP := decode_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f vlog.f --top-module decode_stage
	verilator --lint-only --timing -f vlog.f --top-module $(TOP)

sim:
	verilator --binary --assert -f vlog.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP)

clean:
	rm -rf obj_dir
